/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and fixed register indices
	////////////////////////////////////////////////////////////////////////////

	localparam int data_width     = 32;
	localparam int reg_addr_width = 5;
	localparam int opcode_width   = 6;  // Opcode and funct fields

	localparam logic [reg_addr_width-1:0] jal_link_reg = 5'd31;  // $ra

	////////////////////////////////////////////////////////////////////////////
	// Instruction field encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [opcode_width-1:0] {
		op_rtype = 6'b000_000,
		op_j     = 6'b000_010,
		op_jal   = 6'b000_011,
		op_beq   = 6'b000_100,
		op_bne   = 6'b000_101,
		op_addi  = 6'b001_000,
		op_slti  = 6'b001_010,
		op_andi  = 6'b001_100,
		op_ori   = 6'b001_101,
		op_xori  = 6'b001_110,
		op_lui   = 6'b001_111,
		op_lb    = 6'b100_000,
		op_lh    = 6'b100_001,
		op_lw    = 6'b100_011,
		op_lbu   = 6'b100_100,
		op_lhu   = 6'b100_101,
		op_lwu   = 6'b100_111,
		op_sb    = 6'b101_000,
		op_sh    = 6'b101_001,
		op_sw    = 6'b101_011
	} opcode_e;

	// Only the R-type functions that change the control word
	typedef enum logic [opcode_width-1:0] {
		fn_sllv = 6'b000_100,
		fn_srlv = 6'b000_110,
		fn_srav = 6'b000_111,
		fn_jr   = 6'b001_000,
		fn_jalr = 6'b001_001
	} funct_e;

	typedef enum logic [1:0] {
		imm_sign  = 2'd0,  // Also the value of a zero control word
		imm_zero  = 2'd1,
		imm_upper = 2'd2
	} imm_mode_e;

	////////////////////////////////////////////////////////////////////////////
	// Control groups and the ID/EX bundle
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opcode_e alu_op;
		logic    reg_dst;
		logic    alu_src;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic jump;
		logic branch;
		logic branch_not;
	} mem_ctrl_t;

	typedef struct packed {
		logic mem_to_reg;
		logic reg_write;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
		logic      jr_jalr;
		imm_mode_e imm_mode;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                     ctrl;
		logic [data_width-1:0]     pc;
		logic [data_width-1:0]     rs_data;
		logic [data_width-1:0]     rt_data;
		logic [data_width-1:0]     imm;
		logic [4:0]                shamt;
		logic [reg_addr_width-1:0] rs;
		logic [reg_addr_width-1:0] rt;
		logic [reg_addr_width-1:0] dest_reg;
	} id_ex_t;

endpackage

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  mips_pkg::opcode_e opcode,
	input  mips_pkg::funct_e  funct,
	output mips_pkg::ctrl_t   ctrl
);

	import mips_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Opcode table
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl          = '0;  // Unknown opcodes stay all zero
		ctrl.imm_mode = imm_sign;

		case (opcode)
			op_rtype: begin
				ctrl.ex.alu_op    = op_rtype;
				ctrl.ex.reg_dst   = 1'b1;  // Result goes to rd
				ctrl.wb.reg_write = 1'b1;

				case (funct)
					fn_sllv, fn_srlv, fn_srav: begin
						ctrl.ex.alu_src = 1'b1;  // Variable shifts
					end
					fn_jr: begin
						ctrl.mem.jump     = 1'b1;
						ctrl.wb.reg_write = 1'b0;  // No link write
						ctrl.jr_jalr      = 1'b1;
					end
					fn_jalr: begin
						ctrl.mem.jump = 1'b1;
						ctrl.jr_jalr  = 1'b1;
					end
					default: begin
						ctrl.ex.alu_src = 1'b0;
					end
				endcase
			end

			// Branches compare rs with rt
			op_beq: begin
				ctrl.ex.alu_op  = opcode;
				ctrl.mem.branch = 1'b1;
			end
			op_bne: begin
				ctrl.ex.alu_op      = opcode;
				ctrl.mem.branch_not = 1'b1;
			end

			op_addi, op_slti: begin
				ctrl.ex.alu_op    = opcode;
				ctrl.ex.alu_src   = 1'b1;
				ctrl.wb.reg_write = 1'b1;
			end
			op_andi, op_ori, op_xori: begin
				ctrl.ex.alu_op    = opcode;
				ctrl.ex.alu_src   = 1'b1;
				ctrl.wb.reg_write = 1'b1;
				ctrl.imm_mode     = imm_zero;  // Logical ops zero-extend
			end
			op_lui: begin
				ctrl.ex.alu_op    = opcode;
				ctrl.ex.alu_src   = 1'b1;
				ctrl.wb.reg_write = 1'b1;
				ctrl.imm_mode     = imm_upper;
			end

			// Loads
			op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu: begin
				ctrl.ex.alu_op     = opcode;
				ctrl.ex.alu_src    = 1'b1;  // Base plus offset
				ctrl.mem.mem_read  = 1'b1;
				ctrl.wb.mem_to_reg = 1'b1;
				ctrl.wb.reg_write  = 1'b1;
			end

			// Stores
			op_sb, op_sh, op_sw: begin
				ctrl.ex.alu_op     = opcode;
				ctrl.ex.alu_src    = 1'b1;
				ctrl.mem.mem_write = 1'b1;
			end

			op_j: begin
				ctrl.ex.alu_op  = opcode;
				ctrl.ex.reg_dst = 1'b1;
				ctrl.mem.jump   = 1'b1;
			end
			op_jal: begin
				ctrl.ex.alu_op    = opcode;
				ctrl.ex.reg_dst   = 1'b1;
				ctrl.mem.jump     = 1'b1;
				ctrl.wb.reg_write = 1'b1;  // Link into $ra
			end

			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [mips_pkg::reg_addr_width-1:0] rs,
	input  logic [mips_pkg::reg_addr_width-1:0] rt,
	output logic [mips_pkg::data_width-1:0]     rs_data,
	output logic [mips_pkg::data_width-1:0]     rt_data,
	input  logic                                wb_we,
	input  logic [mips_pkg::reg_addr_width-1:0] wb_addr,
	input  logic [mips_pkg::data_width-1:0]     wb_data
);

	import mips_pkg::*;

	logic [data_width-1:0] regs [1:31];  // $zero has no storage

	// Read port with zero register and write-back bypass
	function automatic logic [data_width-1:0] read_reg(input logic [reg_addr_width-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (wb_we && (wb_addr == addr)) begin
			return wb_data;  // Same-cycle write wins
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs_data = read_reg(rs);
		rt_data = read_reg(rt);
	end

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we && (wb_addr != '0)) begin
			regs[wb_addr] <= wb_data;  // Writes to $zero dropped
		end
	end

endmodule

`default_nettype wire

/* id_ex_register.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_register (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            stall,
	input  logic                            flush,
	input  mips_pkg::ctrl_t                 ctrl,
	input  logic [mips_pkg::data_width-1:0] instr,
	input  logic [mips_pkg::data_width-1:0] pc,
	input  logic [mips_pkg::data_width-1:0] rs_data,
	input  logic [mips_pkg::data_width-1:0] rt_data,
	output mips_pkg::id_ex_t                id_ex
);

	import mips_pkg::*;

	id_ex_t      next_id_ex;
	logic [15:0] imm16;

	assign imm16 = instr[15:0];

	always_comb begin
		next_id_ex         = '0;
		next_id_ex.ctrl    = ctrl;
		next_id_ex.pc      = pc;
		next_id_ex.rs_data = rs_data;
		next_id_ex.rt_data = rt_data;
		next_id_ex.shamt   = instr[10:6];
		next_id_ex.rs      = instr[25:21];
		next_id_ex.rt      = instr[20:16];

		case (ctrl.imm_mode)
			imm_zero:  next_id_ex.imm = {16'h0000, imm16};
			imm_upper: next_id_ex.imm = {imm16, 16'h0000};  // LUI
			default:   next_id_ex.imm = {{16{imm16[15]}}, imm16};
		endcase

		// Link write overrides the rd/rt choice
		if (ctrl.mem.jump && ctrl.wb.reg_write) begin
			next_id_ex.dest_reg = jal_link_reg;
		end else if (ctrl.ex.reg_dst) begin
			next_id_ex.dest_reg = instr[15:11];
		end else begin
			next_id_ex.dest_reg = instr[20:16];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (flush) begin
			id_ex <= '0;  // Bubble, beats stall
		end else if (!stall) begin
			id_ex <= next_id_ex;
		end
	end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [mips_pkg::data_width-1:0]     instr,
	input  logic [mips_pkg::data_width-1:0]     pc,
	input  logic                                stall,
	input  logic                                flush,
	input  logic                                wb_we,
	input  logic [mips_pkg::reg_addr_width-1:0] wb_addr,
	input  logic [mips_pkg::data_width-1:0]     wb_data,
	output mips_pkg::id_ex_t                    id_ex
);

	import mips_pkg::*;

	ctrl_t                 ctrl;
	logic [data_width-1:0] rs_data;
	logic [data_width-1:0] rt_data;

	control_unit u_control_unit (
		.opcode (opcode_e'(instr[31:26])),
		.funct  (funct_e'(instr[5:0])),
		.ctrl   (ctrl)
	);

	register_file u_register_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs      (instr[25:21]),
		.rt      (instr[20:16]),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb_we   (wb_we),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	id_ex_register u_id_ex_register (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall   (stall),
		.flush   (flush),
		.ctrl    (ctrl),
		.instr   (instr),
		.pc      (pc),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.id_ex   (id_ex)
	);

endmodule

`default_nettype wire

/* decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

	import mips_pkg::*;

	typedef struct packed {
		logic                      is_write;
		logic                      use_random;  // Data word from $urandom
		logic [reg_addr_width-1:0] wb_addr;
		logic [data_width-1:0]     wb_data;
		logic [data_width-1:0]     instr;
		logic [data_width-1:0]     pc;
		logic                      stall;
		logic                      flush;
		logic                      use_shadow;  // Operands from the shadow copy
		id_ex_t                    exp_id_ex;
	} trace_rec_t;

	logic                      clk;
	logic                      rst_n;
	logic [data_width-1:0]     instr;
	logic [data_width-1:0]     pc;
	logic                      stall;
	logic                      flush;
	logic                      wb_we;
	logic [reg_addr_width-1:0] wb_addr;
	logic [data_width-1:0]     wb_data;
	id_ex_t                    id_ex;

	trace_rec_t                recs[$];
	logic [data_width-1:0]     shadow [0:31];  // Register contents as the testbench sees them
	logic                      write_pending;
	int                        cycle_count;
	int                        cycle_limit;
	logic [data_width-1:0]     held_pc;  // Expected pc, rs and rt of the bundle
	logic [reg_addr_width-1:0] held_rs;
	logic [reg_addr_width-1:0] held_rt;

	decode_stage u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.instr   (instr),
		.pc      (pc),
		.stall   (stall),
		.flush   (flush),
		.wb_we   (wb_we),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.id_ex   (id_ex)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: trace not finished after %0d cycles", cycle_count);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_ctrl(input string name, input ctrl_t expected, input ctrl_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_word(input string name, input logic [data_width-1:0] expected,
			input logic [data_width-1:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	// Register indices and shamt
	task automatic check_field(input string name, input logic [4:0] expected,
			input logic [4:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Trace file
	////////////////////////////////////////////////////////////////////////////

	task automatic load_trace();
		int               fd;
		int               code;
		logic [7:0]       tag;
		logic [8*160-1:0] rest;
		logic [31:0]      f [0:10];
		trace_rec_t       rec;
		fd = $fopen("decode_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file decode_trace.txt");
			abort_run();
		end
		code = $fscanf(fd, "%s", tag);
		while (code == 1) begin
			rec = '0;
			if (tag == "#") begin
				code = $fgets(rest, fd);  // Skip comment
			end else if (tag == "W") begin
				code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
				if (code != 3) begin
					$display("Malformed write record after %0d records", recs.size());
					abort_run();
				end
				rec.is_write   = 1'b1;
				rec.wb_addr    = f[0][4:0];
				rec.wb_data    = f[1];
				rec.use_random = f[2][0];
				recs.push_back(rec);
			end else if (tag == "D") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
					f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
				if (code != 11) begin
					$display("Malformed decode record after %0d records", recs.size());
					abort_run();
				end
				rec.instr              = f[0];
				rec.pc                 = f[1];
				rec.stall              = f[2][0];
				rec.flush              = f[3][0];
				rec.exp_id_ex.ctrl     = f[4][17:0];
				rec.exp_id_ex.rs_data  = f[5];
				rec.exp_id_ex.rt_data  = f[6];
				rec.exp_id_ex.imm      = f[7];
				rec.exp_id_ex.dest_reg = f[8][4:0];
				rec.exp_id_ex.shamt    = f[9][4:0];
				rec.use_shadow         = f[10][0];
				recs.push_back(rec);
			end else begin
				$display("Unknown record type in the trace file");
				abort_run();
			end
			code = $fscanf(fd, "%s", tag);
		end
		$fclose(fd);
		if (recs.size() == 0) begin
			$display("The trace file holds no records");
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Record handling
	////////////////////////////////////////////////////////////////////////////

	task automatic step_cycle();
		@(negedge clk);
		wb_we         = 1'b0;  // Write went in at the rising edge
		write_pending = 1'b0;
	endtask

	// A write rides along with the next decode
	task automatic apply_write(input trace_rec_t rec);
		if (write_pending) begin
			step_cycle();
		end
		wb_we   = 1'b1;
		wb_addr = rec.wb_addr;
		wb_data = rec.use_random ? $urandom() : rec.wb_data;
		if (rec.wb_addr != '0) begin
			shadow[rec.wb_addr] = wb_data;
		end
		write_pending = 1'b1;
	endtask

	task automatic apply_decode(input trace_rec_t rec);
		logic [data_width-1:0] exp_rs;
		logic [data_width-1:0] exp_rt;
		instr = rec.instr;
		pc    = rec.pc;
		stall = rec.stall;
		flush = rec.flush;
		step_cycle();
		exp_rs = rec.exp_id_ex.rs_data;
		exp_rt = rec.exp_id_ex.rt_data;
		if (rec.use_shadow) begin
			exp_rs = shadow[rec.instr[25:21]];
			exp_rt = shadow[rec.instr[20:16]];
		end
		if (rec.flush) begin
			held_pc = '0;  // Bubble
			held_rs = '0;
			held_rt = '0;
		end else if (!rec.stall) begin
			held_pc = rec.pc;
			held_rs = rec.instr[25:21];
			held_rt = rec.instr[20:16];
		end
		check_ctrl("id_ex.ctrl", rec.exp_id_ex.ctrl, id_ex.ctrl);
		check_word("id_ex.pc", held_pc, id_ex.pc);
		check_word("id_ex.rs_data", exp_rs, id_ex.rs_data);
		check_word("id_ex.rt_data", exp_rt, id_ex.rt_data);
		check_word("id_ex.imm", rec.exp_id_ex.imm, id_ex.imm);
		check_field("id_ex.rs", held_rs, id_ex.rs);
		check_field("id_ex.rt", held_rt, id_ex.rt);
		check_field("id_ex.dest_reg", rec.exp_id_ex.dest_reg, id_ex.dest_reg);
		check_field("id_ex.shamt", rec.exp_id_ex.shamt, id_ex.shamt);
	endtask

	initial begin
		void'($urandom(76));
		rst_n         = 1'b0;
		instr         = '0;
		pc            = '0;
		stall         = 1'b0;
		flush         = 1'b0;
		wb_we         = 1'b0;
		wb_addr       = '0;
		wb_data       = '0;
		write_pending = 1'b0;
		cycle_count   = 0;
		cycle_limit   = 20;
		held_pc       = '0;
		held_rs       = '0;
		held_rt       = '0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		load_trace();
		cycle_limit = 4 * recs.size() + 20;

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_ctrl("id_ex.ctrl after reset", '0, id_ex.ctrl);  // Nothing decoded yet

		foreach (recs[i]) begin
			if (recs[i].is_write) begin
				apply_write(recs[i]);
			end else begin
				apply_decode(recs[i]);
			end
		end
		if (write_pending) begin
			step_cycle();
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* decode_trace.txt */
# W addr data random
# D instr pc stall flush ctrl rs_data rt_data imm dest_reg shamt use_shadow
W 01 00001111 0
W 02 00002222 0
W 03 fffffffd 0
W 00 deadbeef 0
W 05 00000000 1
W 06 00000000 1
D 00222020 00000100 0 0 00808 00001111 00002222 00002020 04 00 0
D 00a13804 00000104 0 0 00c08 00000000 00000000 00003804 07 00 1
D 00224806 00000108 0 0 00c08 00001111 00002222 00004806 09 00 0
D 00435007 0000010c 0 0 00c08 00002222 fffffffd 00005007 0a 00 0
D 00c00008 00000110 0 0 00884 00000000 00000000 00000008 00 00 1
D 00605009 00000114 0 0 0088c fffffffd 00000000 00005009 1f 00 0
D 1001fffc 00000118 0 0 04040 00000000 00001111 fffffffc 01 1f 0
D 14220010 0000011c 0 0 05020 00001111 00002222 00000010 02 00 0
D 20240140 00000120 0 0 08408 00001111 00000000 00000140 04 05 0
D 28658000 00000124 0 0 0a408 00000000 00000000 ffff8000 05 00 1
D 3048ff00 00000128 0 0 0c409 00002222 00000000 0000ff00 08 1c 0
D 34298001 0000012c 0 0 0d409 00001111 00000000 00008001 09 00 0
D 386aabcd 00000130 0 0 0e409 fffffffd 00000000 0000abcd 0a 0f 0
D 3c0b8765 00000134 0 0 0f40a 00000000 00000000 87650000 0b 1d 0
D 802c0004 00000138 0 0 20618 00001111 00000000 00000004 0c 00 0
D 844dfffe 0000013c 0 0 21618 00002222 00000000 fffffffe 0d 1f 0
D 8c6efff0 00000140 0 0 23618 fffffffd 00000000 fffffff0 0e 1f 0
D 902f0008 00000144 0 0 24618 00001111 00000000 00000008 0f 00 0
D 94507ffe 00000148 0 0 25618 00002222 00000000 00007ffe 10 1f 0
D 9c110000 0000014c 0 0 27618 00000000 00000000 00000000 11 00 0
D a0220001 00000150 0 0 28500 00001111 00002222 00000001 02 00 0
D a443fffc 00000154 0 0 29500 00002222 fffffffd fffffffc 03 1f 0
D ac61000c 00000158 0 0 2b500 fffffffd 00001111 0000000c 01 00 0
D 08000040 0000015c 0 0 02880 00000000 00000000 00000040 00 01 0
D 0c123456 00000160 0 0 03888 00000000 00000000 00003456 1f 11 0
D fc221234 00000164 0 0 00000 00001111 00002222 00001234 02 08 0
W 04 0badf00d 0
D 00819820 00000168 0 0 00808 0badf00d 00001111 ffff9820 13 00 0
W 02 55555555 0
D 0042a020 0000016c 1 0 00808 0badf00d 00001111 ffff9820 13 00 0
D 0042a020 0000016c 0 0 00808 55555555 55555555 ffffa020 14 00 0
D 3c0b8765 00000170 1 1 00000 00000000 00000000 00000000 00 00 0

/* build.f */
mips_pkg.sv
control_unit.sv
register_file.sv
id_ex_register.sv
decode_stage.sv
decode_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator, run it and scan its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module decode_stage_tb -f build.f -o decode_stage_sim \
	&& ./obj_dir/decode_stage_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
